// ==== logic/core_pkg.sv ====
/* core-side constants and types for the fetch unit:
   word types, the instruction view, boot pc and queue sizing */
`default_nettype none

package core_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] data_t;

	// one instruction word, seen either whole or as I-type fields
	typedef union packed {
		logic [xlen-1:0] raw;
		struct packed {
			logic [11:0] funct12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fields;
	} instr_u;

	localparam data_t boot_pc = 32'h0000_0000;

	localparam logic [6:0] opcode_system = 7'b111_0011;
	localparam data_t      ecall_word    = 32'h0000_0073;

	// addi x0, x0, 0
	localparam data_t nop_word = 32'h0000_0013;

	localparam int queue_depth_log2  = 4;
	localparam int queue_depth       = 1 << queue_depth_log2;
	// fetch stops issuing reads at this level so the in-flight word still fits
	localparam int queue_almost_full = 14;

endpackage

`default_nettype wire

// ==== logic/bus_pkg.sv ====
/* AXI-Lite read bus widths, response codes and memory byte order */
`default_nettype none

package bus_pkg;

	localparam int axi_addr_w = 32;
	localparam int axi_data_w = 32;

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_exokay = 2'b01,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} axi_resp_e;

	localparam bit mem_little_endian = 1'b1;

	// put a memory word into instruction byte order
	function automatic logic [axi_data_w-1:0] mem_to_core(input logic [axi_data_w-1:0] word);
		if (mem_little_endian)
			return {word[7:0], word[15:8], word[23:16], word[31:24]};
		return word;
	endfunction

endpackage

`default_nettype wire

// ==== logic/instr_bus_reader.sv ====
/* AXI-Lite read master: one rd_req level starts one read,
   the word comes back on rd_data with a single rd_done pulse */
`timescale 1ns/1ps
`default_nettype none

module instr_bus_reader
	import core_pkg::*;
	import bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  logic      rd_req,
	input  data_t     rd_addr,
	output logic      rd_done,
	output data_t     rd_data,

	output data_t     araddr,
	output logic      arvalid,
	input  logic      arready,
	input  data_t     rdata,
	// response code is taken as is
	input  axi_resp_e rresp,
	input  logic      rvalid,
	output logic      rready
);

	enum logic [1:0] {
		st_idle,
		st_addr,
		st_data
	} state;

	logic [axi_addr_w-1:0] addr_q;
	logic [axi_data_w-1:0] data_q;
	logic                  start;
	logic                  beat;

	assign start = (state == st_idle) && rd_req;
	assign beat  = rvalid && rready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_idle;
			arvalid <= 1'b0;
			rready  <= 1'b0;
			rd_done <= 1'b0;
		end else begin
			rd_done <= beat;
			case (state)
				st_idle: begin
					if (rd_req) begin
						state   <= st_addr;
						arvalid <= 1'b1;
					end
				end
				st_addr: begin
					// address held until the slave takes it
					if (arready) begin
						state   <= st_data;
						arvalid <= 1'b0;
						rready  <= 1'b1;
					end
				end
				st_data: begin
					if (rvalid) begin
						state  <= st_idle;
						rready <= 1'b0;
					end
				end
				default: begin
					state   <= st_idle;
					arvalid <= 1'b0;
					rready  <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			addr_q <= rd_addr;
		if (beat)
			data_q <= rdata;
	end

	assign araddr  = addr_q;
	assign rd_data = data_q;

endmodule

`default_nettype wire

// ==== logic/fetch_ctrl.sv ====
/* fetch FSM: owns the pc, issues reads, tracks redirects from flush
   and stops after an ecall until writeback retires it and go returns */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl
	import core_pkg::*;
	import bus_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,

	input  logic  go,
	input  logic  flush,
	input  data_t pc_bj,
	input  data_t instr_w,

	input  logic  rd_done,
	input  data_t rd_data,
	input  logic  almost_full,

	output logic  rd_req,
	output data_t rd_addr,
	output logic  push,
	output data_t push_pc
);

	enum logic [1:0] {
		st_idle,
		st_fetch,
		st_hold,
		st_ecall_wait
	} state, state_nxt;

	data_t  pc;
	data_t  redir_pc;
	logic   redir_pend;
	logic   drop;
	logic   busy;
	logic   kept;
	logic   is_ecall;
	instr_u fetched;

	// decode the returned word in instruction byte order
	assign fetched.raw = mem_to_core(rd_data);
	assign is_ecall = (fetched.i_fields.opcode == opcode_system) &&
		(fetched.i_fields.funct3 == 3'b000) &&
		(fetched.i_fields.rd == 5'd0) &&
		(fetched.i_fields.rs1 == 5'd0) &&
		(fetched.i_fields.funct12 == 12'h000);

	assign push    = rd_done && !drop;
	assign push_pc = pc;
	assign kept    = push && !flush;

	// no new read while a redirect still has to reach the pc
	assign rd_req  = (state == st_fetch) && !busy && !almost_full && !redir_pend && !flush;
	assign rd_addr = pc;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:
				if (go)
					state_nxt = st_fetch;
			st_fetch:
				if (kept && is_ecall)
					state_nxt = st_ecall_wait;
				else if (almost_full)
					state_nxt = st_hold;
			st_hold:
				if (kept && is_ecall)
					state_nxt = st_ecall_wait;
				else if (!almost_full)
					state_nxt = st_fetch;
			st_ecall_wait:
				if (instr_w == ecall_word)
					state_nxt = st_idle;
			default:
				state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			pc         <= boot_pc;
			redir_pc   <= boot_pc;
			redir_pend <= 1'b0;
			drop       <= 1'b0;
			busy       <= 1'b0;
		end else begin
			state <= state_nxt;
			if (rd_req)
				busy <= 1'b1;
			else if (rd_done)
				busy <= 1'b0;

			if (rd_done) begin
				drop       <= 1'b0;
				redir_pend <= 1'b0;
				if (flush)
					pc <= pc_bj;
				else if (redir_pend)
					pc <= redir_pc;
				else
					pc <= pc + 32'd4;
			end else if (flush) begin
				// word in flight is stale, target kept until it lands
				redir_pend <= 1'b1;
				redir_pc   <= pc_bj;
				if (busy)
					drop <= 1'b1;
			end else if (redir_pend && !busy) begin
				pc         <= redir_pc;
				redir_pend <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/instr_queue.sv ====
/* instruction queue between fetch and decode: word and pc pairs,
   emptied by flush, byte order fixed on the way out */
`timescale 1ns/1ps
`default_nettype none

module instr_queue
	import core_pkg::*;
	import bus_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,

	input  logic   push,
	input  data_t  push_data,
	input  data_t  push_pc,

	input  logic   flush,
	input  logic   stall,

	output logic   almost_full,
	output instr_u instr,
	output data_t  pc_out,
	output logic   instr_valid
);

	data_t word_mem [queue_depth];
	data_t pc_mem [queue_depth];

	logic [queue_depth_log2-1:0] wr_ptr;
	logic [queue_depth_log2-1:0] rd_ptr;
	logic [queue_depth_log2:0]   count;
	logic                        flush_q;
	logic                        empty;
	logic                        full;
	logic                        wr_en;
	logic                        rd_en;

	assign empty = (count == '0);
	assign full  = (count == queue_depth[queue_depth_log2:0]);
	assign almost_full = (count >= queue_almost_full[queue_depth_log2:0]);

	assign wr_en = push && !full && !flush;
	// decode takes the head on every valid cycle
	assign rd_en = instr_valid;

	assign instr_valid = !empty && !stall && !flush && !flush_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			flush_q <= 1'b0;
		end else begin
			flush_q <= flush;
			if (flush) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count  <= '0;
			end else begin
				if (wr_en)
					wr_ptr <= wr_ptr + 1'b1;
				if (rd_en)
					rd_ptr <= rd_ptr + 1'b1;
				if (wr_en && !rd_en)
					count <= count + 1'b1;
				else if (rd_en && !wr_en)
					count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			word_mem[wr_ptr] <= push_data;
			pc_mem[wr_ptr]   <= push_pc;
		end
	end

	assign instr.raw = instr_valid ? mem_to_core(word_mem[rd_ptr]) : nop_word;
	assign pc_out    = instr_valid ? pc_mem[rd_ptr] : '0;

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
/* instruction fetch top: bus reader, fetch FSM and instruction queue
   between an AXI-Lite memory and decode */
`timescale 1ns/1ps
`default_nettype none

module fetch_top
	import core_pkg::*;
	import bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  data_t     pc_bj,
	input  logic      flush,
	input  logic      stall,
	input  logic      go,
	input  data_t     instr_w,

	output data_t     araddr,
	output logic      arvalid,
	input  logic      arready,
	input  data_t     rdata,
	input  axi_resp_e rresp,
	input  logic      rvalid,
	output logic      rready,

	output data_t     pc_out,
	output instr_u    instr,
	output logic      instr_valid
);

	logic  rd_req;
	data_t rd_addr;
	logic  rd_done;
	data_t rd_data;
	logic  push;
	data_t push_pc;
	logic  almost_full;

	instr_bus_reader u_reader (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_req  (rd_req),
		.rd_addr (rd_addr),
		.rd_done (rd_done),
		.rd_data (rd_data),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	fetch_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.go          (go),
		.flush       (flush),
		.pc_bj       (pc_bj),
		.instr_w     (instr_w),
		.rd_done     (rd_done),
		.rd_data     (rd_data),
		.almost_full (almost_full),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.push        (push),
		.push_pc     (push_pc)
	);

	instr_queue u_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.push        (push),
		.push_data   (rd_data),
		.push_pc     (push_pc),
		.flush       (flush),
		.stall       (stall),
		.almost_full (almost_full),
		.instr       (instr),
		.pc_out      (pc_out),
		.instr_valid (instr_valid)
	);

endmodule

`default_nettype wire

// ==== tb/fetch_chk.sv ====
/* bus and queue rules as concurrent assertions,
   bound into the bus reader and the instruction queue */
`timescale 1ns/1ps
`default_nettype none

module fetch_chk (
	input wire logic        clk,
	input wire logic        rst_n,
	input wire logic        arvalid,
	input wire logic        arready,
	input wire logic [31:0] araddr,
	input wire logic        push,
	input wire logic        full,
	input wire logic        flush,
	input wire logic        instr_valid
);

	int fail_count = 0;

	// request stays up with the same address until taken
	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			$error("arvalid dropped or araddr changed before arready");
			fail_count++;
		end

	no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> !full)
		else begin
			$error("push arrived while the queue was full");
			fail_count++;
		end

	// nothing valid during flush, and the word in flight never lands right after it
	no_valid_flush: assert property (@(posedge clk) disable iff (!rst_n)
		flush |-> !instr_valid ##1 (!instr_valid && !push))
		else begin
			$error("instr_valid high or a stale push around a flush");
			fail_count++;
		end

endmodule

bind instr_bus_reader fetch_chk u_chk (
	.clk(clk), .rst_n(rst_n), .arvalid(arvalid), .arready(arready), .araddr(araddr),
	.push(1'b0), .full(1'b0), .flush(1'b0), .instr_valid(1'b0)
);

bind instr_queue fetch_chk u_chk (
	.clk(clk), .rst_n(rst_n), .arvalid(1'b0), .arready(1'b0), .araddr(32'h0),
	.push(push), .full(full), .flush(flush), .instr_valid(instr_valid)
);

`default_nettype wire

// ==== tb/fetch_scoreboard.sv ====
/* scoreboard: builds the expected stream from the program
   and checks every instruction handed to decode */
`timescale 1ns/1ps
`default_nettype none

module fetch_scoreboard
	import core_pkg::*;
	import bus_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire logic   instr_valid,
	input  wire data_t  pc_out,
	input  wire instr_u instr,
	input  wire logic   arvalid,
	input  wire logic   arready,
	input  wire data_t  prog [256],
	input  wire logic   load,
	input  wire data_t  load_pc,
	input  wire logic   fill_check,
	input  wire logic   test_end,
	input  wire integer test_num,
	output int          pending,
	output int          errors,
	output int          checks
);

	data_t exp_pc_q[$];
	data_t exp_word_q[$];
	int    test_checks;
	int    test_errors;
	int    rd_issued;

	// k-th entry of the stream from start, none past an ecall
	function automatic bit ref_entry(input data_t start, input int k,
		output data_t pc, output data_t word);
		data_t p;
		p = start;
		for (int i = 0; i < k; i++) begin
			if (prog[p[9:2]] == 32'h0000_0073)
				return 1'b0;
			p = p + 32'd4;
		end
		pc = p;
		word = prog[p[9:2]];
		return 1'b1;
	endfunction

	initial begin
		pending = 0;
		errors = 0;
		checks = 0;
		test_checks = 0;
		test_errors = 0;
		rd_issued = 0;
	end

	always @(posedge clk) begin
		data_t p;
		data_t w;
		int    k;
		// reads since the last target, none once the ecall is out
		if (rst_n && arvalid && arready) begin
			rd_issued++;
			if (exp_pc_q.size() == 0) begin
				$display("read issued with no instruction left to fetch");
				errors++;
				test_errors++;
			end
		end
		if (rst_n && instr_valid) begin
			checks++;
			test_checks++;
			if (exp_pc_q.size() == 0) begin
				$display("unexpected instruction at pc %h with nothing left to deliver", pc_out);
				errors++;
				test_errors++;
			end else begin
				p = exp_pc_q.pop_front();
				w = exp_word_q.pop_front();
				if (pc_out !== p || instr.raw !== w) begin
					if (pc_out !== p)
						$display("FAILED pc_out expected %h got %h", p, pc_out);
					if (instr.raw !== w)
						$display("FAILED instr expected %h got %h", w, instr.raw);
					errors++;
					test_errors++;
				end
			end
		end
		// new target replaces whatever was still expected
		if (load) begin
			exp_pc_q.delete();
			exp_word_q.delete();
			rd_issued = 0;
			k = 0;
			while (ref_entry(load_pc, k, p, w)) begin
				exp_pc_q.push_back(p);
				exp_word_q.push_back(w);
				k++;
			end
		end
		// a queue held by stall takes exactly the almost-full level of reads
		if (fill_check && rd_issued != queue_almost_full) begin
			$display("FAILED rd_issued expected %h got %h", queue_almost_full, rd_issued);
			errors++;
			test_errors++;
		end
		if (test_end) begin
			$display("test %0d done: %0d instructions checked, %0d errors",
				test_num, test_checks, test_errors);
			test_checks = 0;
			test_errors = 0;
		end
		pending = exp_pc_q.size();
	end

endmodule

`default_nettype wire

// ==== tb/fetch_tb.sv ====
/* testbench for fetch_top: AXI-Lite memory with random latency,
   boot, stall, flush and ecall scenarios, watchdog and final report */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
	import core_pkg::*;
	import bus_pkg::*;
;

	localparam int num_tests = 5;
	localparam int test_cycles = 400;
	localparam int fill_cycles = 250;

	logic      clk;
	logic      rst_n;
	data_t     pc_bj;
	logic      flush;
	logic      stall = 1'b0;
	logic      go;
	data_t     instr_w;
	data_t     araddr;
	logic      arvalid;
	logic      arready = 1'b0;
	data_t     rdata = '0;
	axi_resp_e rresp = resp_okay;
	logic      rvalid = 1'b0;
	logic      rready;
	data_t     pc_out;
	instr_u    instr;
	logic      instr_valid;

	data_t      prog [256];
	logic [7:0] mem_bytes [1024];
	logic       load;
	data_t      load_pc;
	logic       fill_check;
	logic       test_end;
	int         test_num;
	int         pending;
	int         sb_errors;
	int         sb_checks;
	int         tb_errors;
	logic       stall_en;
	logic       stall_hold;
	int         total;

	logic [2:0] mstate = 3'd0;
	int         lat_cnt = 0;
	data_t      addr_l = '0;

	fetch_top u_dut (
		.clk(clk), .rst_n(rst_n), .pc_bj(pc_bj), .flush(flush), .stall(stall),
		.go(go), .instr_w(instr_w), .araddr(araddr), .arvalid(arvalid),
		.arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid),
		.rready(rready), .pc_out(pc_out), .instr(instr), .instr_valid(instr_valid)
	);

	fetch_scoreboard u_sb (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .pc_out(pc_out),
		.instr(instr), .arvalid(arvalid), .arready(arready), .prog(prog),
		.load(load), .load_pc(load_pc), .fill_check(fill_check),
		.test_end(test_end), .test_num(test_num), .pending(pending),
		.errors(sb_errors), .checks(sb_checks)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// memory model: random arready and rvalid delays
	// lowest byte address goes out on the top lane
	always @(negedge clk) begin
		if (!rst_n) begin
			mstate <= 3'd0;
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			case (mstate)
				3'd0: if (arvalid) begin
					lat_cnt <= int'($urandom_range(0, 3));
					mstate <= 3'd1;
				end
				3'd1: if (lat_cnt == 0) begin
					arready <= 1'b1;
					addr_l <= araddr;
					mstate <= 3'd2;
				end else
					lat_cnt <= lat_cnt - 1;
				3'd2: begin
					arready <= 1'b0;
					lat_cnt <= int'($urandom_range(0, 3));
					mstate <= 3'd3;
				end
				3'd3: begin
					if (!rready) begin
						$display("rready low while a read was outstanding");
						tb_errors++;
					end
					if (lat_cnt == 0) begin
						rvalid <= 1'b1;
						rdata <= {mem_bytes[{addr_l[9:2], 2'd0}],
							mem_bytes[{addr_l[9:2], 2'd1}],
							mem_bytes[{addr_l[9:2], 2'd2}],
							mem_bytes[{addr_l[9:2], 2'd3}]};
						rresp <= axi_resp_e'($urandom_range(0, 3));
						mstate <= 3'd4;
					end else
						lat_cnt <= lat_cnt - 1;
				end
				default: begin
					rvalid <= 1'b0;
					mstate <= 3'd0;
				end
			endcase
		end
	end

	always @(negedge clk) begin
		if (stall_hold)
			stall <= 1'b1;
		else if (stall_en)
			stall <= ($urandom_range(0, 1) == 1);
		else
			stall <= 1'b0;
	end

	task automatic go_from(input data_t start);
		@(negedge clk);
		go = 1'b1;
		load = 1'b1;
		load_pc = start;
	endtask

	task automatic drive_flush(input data_t target);
		@(negedge clk);
		flush = 1'b1;
		pc_bj = target;
		load = 1'b1;
		load_pc = target;
	endtask

	task automatic release_strobes();
		@(negedge clk);
		go = 1'b0;
		flush = 1'b0;
		load = 1'b0;
	endtask

	task automatic wait_stream(input int n);
		int cyc;
		cyc = 0;
		while (pending != 0 && cyc < test_cycles) begin
			@(negedge clk);
			cyc++;
		end
		if (pending != 0) begin
			$display("test %0d timed out with %0d instructions never delivered", n, pending);
			tb_errors++;
		end
		// room for any extra instruction to show up
		repeat (10) @(negedge clk);
		test_num = n;
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	task automatic retire_ecall();
		@(negedge clk);
		instr_w = ecall_word;
		@(negedge clk);
		instr_w = '0;
	endtask

	initial begin
		void'($urandom(8));
		rst_n = 1'b0;
		pc_bj = '0;
		flush = 1'b0;
		go = 1'b0;
		instr_w = '0;
		load = 1'b0;
		load_pc = '0;
		fill_check = 1'b0;
		test_end = 1'b0;
		test_num = 0;
		tb_errors = 0;
		stall_en = 1'b0;
		stall_hold = 1'b0;
		// addi x1, x2, imm with a per-word immediate, ecalls in between
		for (int i = 0; i < 256; i++)
			prog[i] = {12'(i * 3 + 1), 5'd2, 3'b000, 5'd1, 7'b001_0011};
		prog[16] = ecall_word;
		prog[48] = ecall_word;
		prog[100] = ecall_word;
		prog[140] = ecall_word;
		prog[160] = ecall_word;
		prog[220] = ecall_word;
		for (int i = 0; i < 256; i++)
			for (int b = 0; b < 4; b++)
				mem_bytes[i * 4 + b] = prog[i][b*8 +: 8];
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		go_from(boot_pc);
		release_strobes();
		wait_stream(1);
		retire_ecall();

		// decode held off until the queue fills and fetch has to wait
		stall_hold = 1'b1;
		go_from(32'h44);
		release_strobes();
		repeat (fill_cycles) @(negedge clk);
		fill_check = 1'b1;
		@(negedge clk);
		fill_check = 1'b0;
		stall_hold = 1'b0;
		stall_en = 1'b1;
		wait_stream(2);
		stall_en = 1'b0;
		retire_ecall();

		go_from(32'hc4);
		release_strobes();
		repeat ($urandom_range(12, 20)) @(negedge clk);
		drive_flush(32'h200);
		release_strobes();
		wait_stream(3);
		retire_ecall();

		go_from(32'h234);
		release_strobes();
		wait_stream(4);
		retire_ecall();

		go_from(32'h284);
		release_strobes();
		repeat (6) @(negedge clk);
		drive_flush(32'h100);
		drive_flush(32'h300);
		release_strobes();
		repeat (3) @(negedge clk);
		drive_flush(32'h348);
		release_strobes();
		wait_stream(5);

		total = sb_errors + tb_errors + u_dut.u_reader.u_chk.fail_count +
			u_dut.u_queue.u_chk.fail_count;
		$display("summary: %0d tests, %0d instructions checked, %0d errors",
			num_tests, sb_checks, total);
		if (total == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		repeat (num_tests * test_cycles + fill_cycles + 500) @(posedge clk);
		$display("watchdog expired before all tests finished");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
logic/core_pkg.sv
logic/bus_pkg.sv
logic/instr_bus_reader.sv
logic/fetch_ctrl.sv
logic/instr_queue.sv
logic/fetch_top.sv
tb/fetch_chk.sv
tb/fetch_scoreboard.sv
tb/fetch_tb.sv

// ==== Makefile ====
# Verilator build and run for the fetch unit testbench
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= fetch_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
